// File: all.f
src/cpuPkg.sv
src/regFile.sv
src/alu.sv
src/opDecoder.sv
src/execControl.sv
src/cpuCore.sv
test/codeRom.sv
test/cpuTb.sv

// File: test/cpuTb.sv
module cpuTb
    import cpuPkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk25;
    logic reset;
    wordT fetchAddr;
    byteT fetchData;
    wordT portAddr;
    wordT portData;
    logic portWide;
    logic portWrite;
    logic portRead;
    wordT portIn;

    portReqT writeQ[$];   // Seen on the bus
    portReqT readQ[$];
    portReqT expWriteQ[$];
    wordT    expReadQ[$];
    logic    prevWrite;
    logic    prevRead;
    int      seedDummy;
    wordT    inValue;     // Answer to the next port read
    int      holdCount;

    cpuCore i_cpuCore (
        .clk25     (clk25),
        .reset     (reset),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .portAddr  (portAddr),
        .portData  (portData),
        .portWide  (portWide),
        .portWrite (portWrite),
        .portRead  (portRead),
        .portIn    (portIn)
    );

    codeRom codeMem (
        .addr (fetchAddr),
        .data (fetchData)
    );

    always #5 clk25 = ~clk25;

    // --------------------
    // Failure reporting and compares
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp)
            abortRun($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkFlags(input string name, input flagsT got, input flagsT exp);
        if (got !== exp)
            abortRun($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkBool(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    endtask

    // --------------------
    // Port bus monitor, sampled away from the rising edge
    always @(negedge clk25) begin
        if (reset) begin
            prevWrite = 1'b0;
            prevRead  = 1'b0;
        end else begin
            if (portWrite && portRead)
                abortRun("portWrite and portRead were high in the same cycle");
            if (portWrite && prevWrite)
                abortRun("portWrite stayed high for more than one cycle");
            if (portRead && prevRead)
                abortRun("portRead stayed high for more than one cycle");
            if (portWrite)
                writeQ.push_back('{addr: portAddr, data: portData, wide: portWide,
                                   write: 1'b1, read: 1'b0});
            if (portRead)
                readQ.push_back('{addr: portAddr, data: '0, wide: portWide,
                                  write: 1'b0, read: 1'b1});
            prevWrite = portWrite;
            prevRead  = portRead;
        end
    end

    // --------------------
    // Port input responder
    // Value is valid from the edge after the read pulse up to the sample edge
    always @(posedge clk25) begin
        if (portRead) begin
            portIn    <= inValue;
            holdCount <= InReadWait - 1;
        end else if (holdCount != 0) begin
            holdCount <= holdCount - 1;
        end else begin
            portIn <= ~inValue;   // Wrong data outside the window
        end
    end

    // --------------------
    // Program and reset sequencing
    task automatic beginProgram();
        @(posedge clk25);
        reset <= 1'b1;
        codeMem.startProgram();
        expWriteQ.delete();
        expReadQ.delete();
    endtask

    task automatic runProgram();
        repeat (15) @(posedge clk25);
        @(negedge clk25);
        checkWord("fetchAddr", fetchAddr, ResetIp);   // Reset vector
        @(posedge clk25);
        writeQ.delete();
        readQ.delete();
        reset <= 1'b0;
    endtask

    task automatic movImm16(input regSelT r, input wordT v);
        codeMem.emit({5'b10111, r});
        codeMem.emitWord(v);
    endtask

    task automatic movImm8(input regSelT r, input byteT v);
        codeMem.emit({5'b10110, r});
        codeMem.emit(v);
    endtask

    task automatic outAx(input byteT p);
        codeMem.emit(8'hE7);
        codeMem.emit(p);
    endtask

    task automatic haltHere();
        codeMem.emit(8'hEB);   // JMP to itself
        codeMem.emit(8'hFE);
    endtask

    task automatic expectOut(input wordT a, input wordT d, input logic w);
        expWriteQ.push_back('{addr: a, data: d, wide: w, write: 1'b1, read: 1'b0});
    endtask

    task automatic takeWrite(output portReqT got);
        int waited;
        waited = 0;
        while (writeQ.size() == 0) begin
            if (waited == 400)
                abortRun("timed out waiting for a port write");
            @(posedge clk25);
            waited++;
        end
        got = writeQ.pop_front();
    endtask

    task automatic checkPortTraffic();
        portReqT got;
        portReqT exp;
        int      waited;
        while (expWriteQ.size() != 0) begin
            exp = expWriteQ.pop_front();
            takeWrite(got);
            checkWord("portAddr", got.addr, exp.addr);
            checkWord("portData", got.data, exp.data);
            checkBool("portWide", got.wide, exp.wide);
        end
        while (expReadQ.size() != 0) begin
            waited = 0;
            while (readQ.size() == 0) begin
                if (waited == 400)
                    abortRun("timed out waiting for a port read");
                @(posedge clk25);
                waited++;
            end
            got = readQ.pop_front();
            checkWord("portAddr on read", got.addr, expReadQ.pop_front());
        end
    endtask

    // --------------------
    // Reference model of the x86 ALU rules
    function automatic void aluModel(input aluOpT op, input wordT a, input wordT b,
                                     input logic w, input flagsT fin,
                                     output wordT res, output flagsT f);
        int unsigned mask;
        int unsigned top;
        int unsigned x;
        int unsigned y;
        int unsigned c;
        int unsigned r;
        mask = w ? 32'hFFFF : 32'hFF;
        top  = w ? 32'h8000 : 32'h80;
        x    = a & mask;
        y    = b & mask;
        c    = (op == AluAdc || op == AluSbb) ? fin.cf : 0;
        f    = fin;
        case (op)
            AluOr:          r = x | y;
            AluAnd:         r = x & y;
            AluXor:         r = x ^ y;
            AluAdd, AluAdc: r = x + y + c;
            default:        r = x - y - c;
        endcase
        if (op == AluOr || op == AluAnd || op == AluXor) begin
            f.of = 1'b0;
            f.cf = 1'b0;
            f.af = 1'b0;
        end else if (op == AluAdd || op == AluAdc) begin
            f.cf = r > mask;
            f.af = (x & 15) + (y & 15) + c > 15;
            f.of = ((x ^ y) & top) == 0 && ((x ^ r) & top) != 0;
        end else begin
            f.cf = x < y + c;   // Borrow
            f.af = (x & 15) < (y & 15) + c;
            f.of = ((x ^ y) & top) != 0 && ((x ^ r) & top) != 0;
        end
        res  = wordT'(r & mask);
        f.zf = (res == 16'h0000);
        f.sf = (r & top) != 0;
        f.pf = ~^res[7:0];
    endfunction

    function automatic logic condModel(input flagsT f, input condSelT c);
        case (c)
            CondO:   return f.of;
            CondC:   return f.cf;
            CondZ:   return f.zf;
            CondBe:  return f.cf | f.zf;
            CondS:   return f.sf;
            CondP:   return f.pf;
            CondL:   return f.sf ^ f.of;
            default: return (f.sf ^ f.of) | f.zf;
        endcase
    endfunction

    // --------------------
    // Directed tests
    task automatic testMovImm();
        wordT axVal;
        byteT b;
        byteT p;
        beginProgram();
        for (int i = 0; i < 4; i++) begin
            axVal = wordT'($urandom);
            p = byteT'($urandom);
            movImm16(3'd0, axVal);
            outAx(p);
            expectOut({8'h00, p}, axVal, 1'b1);
            b = byteT'($urandom);
            movImm8(3'd4, b);   // AH
            axVal[15:8] = b;
            outAx(p + 8'd1);
            expectOut({8'h00, p + 8'd1}, axVal, 1'b1);
            b = byteT'($urandom);
            movImm8(3'd0, b);
            codeMem.emit(8'hE6);   // Byte OUT of AL
            codeMem.emit(p);
            expectOut({8'h00, p}, {8'h00, b}, 1'b0);
        end
        haltHere();
        runProgram();
        checkPortTraffic();
    endtask

    task automatic testAluImm();
        wordT  a;
        wordT  b;
        wordT  res;
        logic  c;
        flagsT fin;
        flagsT fexp;
        aluOpT op;
        for (int i = 0; i < 16; i++) begin
            op = aluOpT'(i % 8);
            a = wordT'($urandom);
            b = wordT'($urandom);
            c = 1'($urandom);
            beginProgram();
            movImm16(3'd0, a);
            codeMem.emit(c ? 8'hF9 : 8'hF8);
            codeMem.emit({2'b00, op, 2'b10, 1'(i / 8)});
            codeMem.emit(b[7:0]);
            if (i >= 8)
                codeMem.emit(b[15:8]);
            outAx(8'h10);
            haltHere();
            fin = FlagsReset;
            fin.cf = c;
            aluModel(op, a, b, 1'(i / 8), fin, res, fexp);
            if (op == AluCmp)
                res = a;
            else if (i < 8)
                res = {a[15:8], res[7:0]};
            expectOut(16'h0010, res, 1'b1);
            runProgram();
            checkPortTraffic();
            checkFlags("flags", i_cpuCore.flags, fexp);
        end
    endtask

    task automatic testAluModRm();
        wordT   a;
        wordT   b;
        wordT   res;
        logic   c;
        logic   w;
        logic   d;
        regSelT r;
        flagsT  fin;
        flagsT  fexp;
        aluOpT  op;
        for (int i = 0; i < 16; i++) begin
            op = aluOpT'(i % 8);
            w = 1'(i / 8);
            d = 1'($urandom);
            r = regSelT'(1 + $urandom % 7);
            a = wordT'($urandom);
            b = wordT'($urandom);
            c = 1'($urandom);
            beginProgram();
            movImm16(3'd0, a);
            if (w)
                movImm16(r, b);
            else
                movImm8(r, b[7:0]);
            codeMem.emit(c ? 8'hF9 : 8'hF8);
            codeMem.emit({2'b00, op, 1'b0, d, w});
            // Destination is AX or AL in both directions
            codeMem.emit(d ? {ModRegReg, 3'd0, r} : {ModRegReg, r, 3'd0});
            outAx(8'h18);
            haltHere();
            if (!w && r == 3'd4)
                a[15:8] = b[7:0];
            fin = FlagsReset;
            fin.cf = c;
            aluModel(op, a, b, w, fin, res, fexp);
            if (op == AluCmp)
                res = a;
            else if (!w)
                res = {a[15:8], res[7:0]};
            expectOut(16'h0018, res, 1'b1);
            runProgram();
            checkPortTraffic();
            checkFlags("flags", i_cpuCore.flags, fexp);
        end
    endtask

    task automatic testJcc();
        wordT    a;
        wordT    b;
        wordT    res;
        flagsT   f;
        portReqT got;
        condSelT cond;
        for (int i = 0; i < 16; i++) begin
            cond = condSelT'(i / 2);
            a = wordT'($urandom);
            b = ($urandom % 4 == 0) ? a : wordT'($urandom);
            beginProgram();
            movImm16(3'd0, a);
            codeMem.emit(8'h3D);   // CMP AX, imm16
            codeMem.emitWord(b);
            codeMem.emit({4'h7, cond, 1'(i % 2)});
            codeMem.emit(8'h04);
            codeMem.emit(8'hE6);   // Fall-through marker
            codeMem.emit(8'h20);
            haltHere();
            codeMem.emit(8'hE6);   // Taken marker
            codeMem.emit(8'h21);
            haltHere();
            aluModel(AluCmp, a, b, 1'b1, FlagsReset, res, f);
            runProgram();
            takeWrite(got);
            checkBool("jump taken", got.addr == 16'h0021, condModel(f, cond) ^ 1'(i % 2));
        end
    endtask

    task automatic testIncDecJmp();
        regSelT r;
        wordT   v;
        r = regSelT'(1 + $urandom % 7);
        v = wordT'($urandom);
        beginProgram();
        movImm16(r, 16'hFFFF);
        codeMem.emit({5'b01000, r});   // INC r
        movImm16(3'd0, 16'h0000);
        codeMem.emit(8'h0B);           // OR AX, r
        codeMem.emit({ModRegReg, 3'd0, r});
        outAx(8'h30);
        expectOut(16'h0030, 16'h0000, 1'b1);
        movImm16(r, 16'h0000);
        codeMem.emit({5'b01001, r});   // DEC r
        movImm16(3'd0, 16'h0000);
        codeMem.emit(8'h0B);
        codeMem.emit({ModRegReg, 3'd0, r});
        outAx(8'h31);
        expectOut(16'h0031, 16'hFFFF, 1'b1);
        movImm16(3'd0, v);
        codeMem.emit(8'hEB);
        codeMem.emit(8'h02);
        outAx(8'h40);                  // Must be skipped
        outAx(8'h41);
        expectOut(16'h0041, v, 1'b1);
        codeMem.emit(8'hE9);
        codeMem.emitWord(16'h0002);
        outAx(8'h42);                  // Must be skipped
        outAx(8'h43);
        expectOut(16'h0043, v, 1'b1);
        haltHere();
        runProgram();
        checkPortTraffic();
    endtask

    task automatic testPortIn();
        wordT v;
        wordT dxVal;
        byteT p;
        v = wordT'($urandom);
        dxVal = wordT'($urandom);
        p = byteT'($urandom);
        beginProgram();
        inValue = v;                   // Returned by the responder
        codeMem.emit(8'hE5);
        codeMem.emit(p);
        expReadQ.push_back({8'h00, p});
        outAx(8'h50);
        expectOut(16'h0050, v, 1'b1);
        movImm16(3'd2, dxVal);
        codeMem.emit(8'hED);
        expReadQ.push_back(dxVal);
        outAx(8'h51);
        expectOut(16'h0051, v, 1'b1);
        movImm16(3'd0, 16'h0000);
        codeMem.emit(8'hEC);
        expReadQ.push_back(dxVal);
        outAx(8'h52);
        expectOut(16'h0052, {8'h00, v[7:0]}, 1'b1);
        haltHere();
        runProgram();
        checkPortTraffic();
    endtask

    initial begin
        clk25 = 1'b0;
        reset = 1'b1;
        portIn = '0;
        inValue = '0;
        holdCount = 0;
        seedDummy = $urandom(1);
        testMovImm();
        testAluImm();
        testAluModRm();
        testJcc();
        testIncDecJmp();
        testPortIn();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: test/codeRom.sv
module codeRom
    import cpuPkg::*;
(
    input  wordT addr,
    output byteT data
);

    timeunit 1ns;
    timeprecision 100ps;

    byteT mem [65536];
    wordT loadPtr;

    assign data = mem[addr];   // Combinational, same cycle as the address

    // Background bytes mix both address halves
    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = byteT'(a[7:0] ^ a[15:8] ^ 8'h5A);
        end
        loadPtr = ResetIp;
    end

    // --------------------
    // Program loading
    task automatic startProgram();
        loadPtr = ResetIp;
    endtask

    task automatic emit(input byteT b);
        mem[loadPtr] = b;
        loadPtr = loadPtr + 16'd1;   // Wraps past FFFF like the core
    endtask

    task automatic emitWord(input wordT w);
        emit(w[7:0]);
        emit(w[15:8]);
    endtask

endmodule

// File: src/cpuCore.sv
module cpuCore
    import cpuPkg::*;
(
    input  logic clk25,
    input  logic reset,

    output wordT fetchAddr,
    input  byteT fetchData,

    output wordT portAddr,
    output wordT portData,
    output logic portWide,
    output logic portWrite,
    output logic portRead,
    input  wordT portIn
);

    byteT     opcode;
    decodedT  dec;
    regWriteT regWr;
    regSelT   rdSel;
    logic     rdWide;
    wordT     rdData;
    wordT     ax;
    wordT     dx;
    wordT     opA;
    wordT     opB;
    aluOpT    aluOp;
    logic     aluWide;
    flagsT    flags;
    wordT     result;
    flagsT    newFlags;
    portReqT  portReq;

    opDecoder i_opDecoder (
        .opcode (opcode),
        .dec    (dec)
    );

    execControl i_execControl (
        .clk25     (clk25),
        .reset     (reset),
        .opcode    (opcode),
        .dec       (dec),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .regWr     (regWr),
        .rdSel     (rdSel),
        .rdWide    (rdWide),
        .rdData    (rdData),
        .ax        (ax),
        .dx        (dx),
        .opA       (opA),
        .opB       (opB),
        .aluOp     (aluOp),
        .aluWide   (aluWide),
        .flags     (flags),
        .result    (result),
        .newFlags  (newFlags),
        .port      (portReq),
        .portIn    (portIn)
    );

    regFile i_regFile (
        .clk25  (clk25),
        .reset  (reset),
        .wr     (regWr),
        .rdSel  (rdSel),
        .rdWide (rdWide),
        .rdData (rdData),
        .ax     (ax),
        .dx     (dx)
    );

    alu i_alu (
        .opA      (opA),
        .opB      (opB),
        .aluOp    (aluOp),
        .wide     (aluWide),
        .flagsIn  (flags),
        .result   (result),
        .newFlags (newFlags)
    );

    // Port bus out of the request struct
    assign portAddr  = portReq.addr;
    assign portData  = portReq.data;
    assign portWide  = portReq.wide;
    assign portWrite = portReq.write;
    assign portRead  = portReq.read;

endmodule

// File: src/execControl.sv
module execControl
    import cpuPkg::*;
(
    input  logic     clk25,
    input  logic     reset,

    output byteT     opcode,
    input  decodedT  dec,

    output wordT     fetchAddr,
    input  byteT     fetchData,

    output regWriteT regWr,
    output regSelT   rdSel,
    output logic     rdWide,
    input  wordT     rdData,
    input  wordT     ax,
    input  wordT     dx,

    output wordT     opA,
    output wordT     opB,
    output aluOpT    aluOp,
    output logic     aluWide,
    output flagsT    flags,
    input  wordT     result,
    input  flagsT    newFlags,

    output portReqT  port,
    input  wordT     portIn
);

    typedef enum logic [1:0] {
        phFetch,
        phModRm,
        phExec
    } phaseT;

    phaseT      phase;
    logic [2:0] micro;      // Step inside the execute phase
    wordT       ip;
    byteT       opReg;
    byteT       modrm;
    wordT       tmp;        // Immediate or first operand
    wordT       ipInc;
    wordT       rel8;
    logic       condVal;
    logic       taken;
    logic       isOut;
    logic       accLast;
    logic       inDone;

    // Decode straight off the bus while fetching
    assign opcode    = (phase == phFetch) ? fetchData : opReg;
    assign fetchAddr = ip;
    assign ipInc     = ip + 16'd1;
    assign rel8      = {{8{fetchData[7]}}, fetchData};
    assign isOut     = opReg[1];
    assign accLast   = (micro == (dec.wide ? 3'd2 : 3'd1));
    assign inDone    = (micro == 3'(InReadWait + 1));

    // --------------------
    // Jcc condition
    always_comb begin
        unique case (dec.cond)
            CondO:  condVal = flags.of;
            CondC:  condVal = flags.cf;
            CondZ:  condVal = flags.zf;
            CondBe: condVal = flags.cf | flags.zf;
            CondS:  condVal = flags.sf;
            CondP:  condVal = flags.pf;
            CondL:  condVal = flags.sf ^ flags.of;
            CondLe: condVal = (flags.sf ^ flags.of) | flags.zf;
        endcase
    end

    assign taken = condVal ^ opReg[0];

    // --------------------
    // Register file and ALU operands
    always_comb begin
        rdSel   = dec.regIdx;
        rdWide  = dec.wide;
        opA     = rdData;
        opB     = tmp;
        aluOp   = dec.aluOp;
        aluWide = dec.wide;
        regWr   = '{en: 1'b0, sel: dec.regIdx, wide: dec.wide, data: result};

        if (phase == phExec) begin
            case (dec.cls)
                aluModRm: begin
                    // Step 0 reads reg, step 1 reads rm and computes
                    rdSel = (micro == 3'd0) ? modrm[5:3] : modrm[2:0];
                    if (dec.dirRegRm) begin
                        opA = tmp;
                        opB = rdData;
                    end
                    regWr.en  = (micro != 3'd0) && (dec.aluOp != AluCmp);
                    regWr.sel = dec.dirRegRm ? modrm[5:3] : modrm[2:0];
                end
                aluAccImm: regWr.en = accLast && (dec.aluOp != AluCmp);
                movRegImm: begin
                    regWr.en   = (micro == {2'b00, dec.wide});
                    regWr.data = dec.wide ? {fetchData, tmp[7:0]} : {8'h00, fetchData};
                end
                incDec: begin
                    opA      = tmp;
                    opB      = 16'd1;
                    regWr.en = (micro != 3'd0);
                end
                inOut: begin
                    regWr.en   = !isOut && inDone;   // IN result to AL/AX
                    regWr.sel  = RegAx;
                    regWr.data = portIn;
                end
                default: regWr.en = 1'b0;
            endcase
        end
    end

    // --------------------
    // Phase sequencing
    always_ff @(posedge clk25) begin
        if (reset) begin
            phase      <= phFetch;
            micro      <= '0;
            ip         <= ResetIp;
            flags      <= FlagsReset;
            port.write <= 1'b0;
            port.read  <= 1'b0;
        end else begin
            port.write <= 1'b0;     // Strobes last one cycle
            port.read  <= 1'b0;

            unique case (phase)
                phFetch: begin
                    opReg <= fetchData;
                    micro <= '0;
                    ip    <= ipInc;
                    case (dec.cls)
                        nop:      phase <= phFetch;
                        flagOp:   flags.cf <= fetchData[3] ? fetchData[0] : ~flags.cf;
                        aluModRm: phase <= phModRm;
                        default:  phase <= phExec;
                    endcase
                end

                phModRm: begin
                    modrm <= fetchData;
                    ip    <= ipInc;
                    // Memory forms are skipped
                    phase <= (fetchData[7:6] == ModRegReg) ? phExec : phFetch;
                end

                phExec: begin
                    micro <= micro + 3'd1;
                    case (dec.cls)
                        aluModRm: begin
                            tmp <= rdData;
                            if (micro != 3'd0) begin
                                flags <= newFlags;
                                phase <= phFetch;
                            end
                        end

                        aluAccImm: begin
                            if (accLast) begin
                                flags <= newFlags;
                                phase <= phFetch;
                            end else begin
                                ip <= ipInc;
                                if (micro == 3'd0)
                                    tmp <= {8'h00, fetchData};
                                else
                                    tmp[15:8] <= fetchData;
                            end
                        end

                        movRegImm: begin
                            ip       <= ipInc;
                            tmp[7:0] <= fetchData;
                            if (micro == {2'b00, dec.wide})
                                phase <= phFetch;
                        end

                        incDec: begin
                            tmp <= rdData;
                            if (micro != 3'd0) begin
                                flags <= {newFlags[11:1], flags.cf};   // CF kept
                                phase <= phFetch;
                            end
                        end

                        jcc: begin
                            ip    <= taken ? ipInc + rel8 : ipInc;
                            phase <= phFetch;
                        end

                        jmpRel: begin
                            if (!dec.wide) begin
                                ip    <= ipInc + rel8;
                                phase <= phFetch;
                            end else if (micro == 3'd0) begin
                                tmp[7:0] <= fetchData;
                                ip       <= ipInc;
                            end else begin
                                ip    <= ipInc + {fetchData, tmp[7:0]};
                                phase <= phFetch;
                            end
                        end

                        inOut: begin
                            if (micro == 3'd0) begin
                                port.addr  <= dec.portFromDx ? dx : {8'h00, fetchData};
                                port.data  <= dec.wide ? ax : {8'h00, ax[7:0]};
                                port.wide  <= dec.wide;
                                port.write <= isOut;
                                port.read  <= !isOut;
                                if (!dec.portFromDx)
                                    ip <= ipInc;
                                if (isOut)
                                    phase <= phFetch;
                            end else if (inDone) begin
                                phase <= phFetch;
                            end
                        end

                        default: phase <= phFetch;
                    endcase
                end

                default: phase <= phFetch;
            endcase
        end
    end

    // --------------------
    // Checks
    assert property (@(posedge clk25) disable iff (reset)
        phase inside {phFetch, phModRm, phExec})
        else $error("phase left its legal range");

    assert property (@(posedge clk25) disable iff (reset) !(port.write && port.read))
        else $error("port read and write strobes overlap");

endmodule

// File: src/opDecoder.sv
module opDecoder
    import cpuPkg::*;
(
    input  byteT    opcode,
    output decodedT dec
);

    always_comb begin
        // Field positions shared by most opcodes
        dec.cls        = nop;
        dec.aluOp      = aluOpT'(opcode[5:3]);
        dec.wide       = opcode[0];
        dec.dirRegRm   = opcode[1];
        dec.regIdx     = opcode[2:0];
        dec.cond       = condSelT'(opcode[3:1]);
        dec.portFromDx = opcode[3];

        casez (opcode)
            8'b00???0??: dec.cls = aluModRm;
            8'b00???10?: begin
                dec.cls    = aluAccImm;
                dec.regIdx = RegAx;
            end
            8'b1011????: begin
                dec.cls  = movRegImm;   // B0-B7 bytes, B8-BF words
                dec.wide = opcode[3];
            end
            8'b0100????: begin
                dec.cls   = incDec;
                dec.wide  = 1'b1;
                dec.aluOp = opcode[3] ? AluSub : AluAdd;
            end
            8'b0111????: dec.cls = jcc;
            8'b1110_10?1: begin
                dec.cls  = jmpRel;
                dec.wide = ~opcode[1];  // E9 rel16, EB rel8
            end
            8'b1111_0101,
            8'b1111_100?: dec.cls = flagOp;   // CMC, CLC, STC
            8'b1110_?1??: dec.cls = inOut;
            default: dec.cls = nop;
        endcase
    end

endmodule

// File: src/alu.sv
module alu
    import cpuPkg::*;
(
    input  wordT  opA,
    input  wordT  opB,
    input  aluOpT aluOp,
    input  logic  wide,
    input  flagsT flagsIn,
    output wordT  result,
    output flagsT newFlags
);

    wordT        a;
    wordT        b;
    logic        isSub;
    logic        isLogic;
    logic        carryIn;
    logic [16:0] sum;
    logic        signA;
    logic        signB;
    logic        signR;
    logic        carryOut;

    // Byte ops see only the low half
    assign a = wide ? opA : {8'h00, opA[7:0]};
    assign b = wide ? opB : {8'h00, opB[7:0]};

    assign isSub   = aluOp inside {AluSbb, AluSub, AluCmp};
    assign isLogic = aluOp inside {AluOr, AluAnd, AluXor};
    assign carryIn = flagsIn.cf && (aluOp inside {AluAdc, AluSbb});

    // --------------------
    // Result, 17 bits wide so the top bit is the carry
    always_comb begin
        case (aluOp)
            AluOr:   sum = {1'b0, a | b};
            AluAnd:  sum = {1'b0, a & b};
            AluXor:  sum = {1'b0, a ^ b};
            default: begin
                if (isSub)
                    sum = {1'b0, a} - {1'b0, b} - 17'(carryIn);   // Borrow shows as bit 16/8
                else
                    sum = {1'b0, a} + {1'b0, b} + 17'(carryIn);
            end
        endcase
    end

    assign signA    = wide ? a[15] : a[7];
    assign signB    = wide ? b[15] : b[7];
    assign signR    = wide ? sum[15] : sum[7];
    assign carryOut = wide ? sum[16] : sum[8];
    assign result   = wide ? sum[15:0] : {8'h00, sum[7:0]};

    // --------------------
    // Flags
    always_comb begin
        newFlags    = flagsIn;   // DF, IF, TF untouched
        newFlags.sf = signR;
        newFlags.zf = wide ? (sum[15:0] == 16'h0000) : (sum[7:0] == 8'h00);
        newFlags.pf = ~^sum[7:0];   // Even parity, low byte only
        if (isLogic) begin
            newFlags.of = 1'b0;
            newFlags.cf = 1'b0;
            newFlags.af = 1'b0;
        end else begin
            // Overflow rules differ for add and subtract
            if (isSub)
                newFlags.of = (signA != signB) && (signR != signA);
            else
                newFlags.of = (signA == signB) && (signR != signA);
            newFlags.cf = carryOut;
            newFlags.af = a[4] ^ b[4] ^ sum[4];   // Carry or borrow into bit 4
        end
    end

endmodule

// File: src/regFile.sv
module regFile
    import cpuPkg::*;
(
    input  logic     clk25,
    input  logic     reset,
    input  regWriteT wr,
    input  regSelT   rdSel,
    input  logic     rdWide,
    output wordT     rdData,
    output wordT     ax,
    output wordT     dx
);

    wordT regs [8];

    // Byte select 4..7 lands in the high half of AX..BX
    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            if (wr.wide)
                regs[wr.sel] <= wr.data;
            else if (wr.sel[2])
                regs[{1'b0, wr.sel[1:0]}][15:8] <= wr.data[7:0];
            else
                regs[wr.sel][7:0] <= wr.data[7:0];
        end
    end

    always_comb begin
        if (rdWide)
            rdData = regs[rdSel];
        else if (rdSel[2])
            rdData = {8'h00, regs[{1'b0, rdSel[1:0]}][15:8]};   // AH, CH, DH, BH
        else
            rdData = {8'h00, regs[rdSel][7:0]};
    end

    assign ax = regs[0];
    assign dx = regs[2];

    // Control must come out of reset idle
    assert property (@(posedge clk25) reset |=> !wr.en)
        else $error("register write right after reset");

endmodule

// File: src/cpuPkg.sv
package cpuPkg;

    // --------------------
    // Basic types
    typedef logic [15:0] wordT;
    typedef logic [7:0]  byteT;
    typedef logic [2:0]  regSelT;   // AX CX DX BX SP BP SI DI, or AL..BH for bytes

    typedef enum logic [2:0] {
        AluAdd,
        AluOr,
        AluAdc,
        AluSbb,
        AluAnd,
        AluSub,
        AluXor,
        AluCmp
    } aluOpT;

    // Jcc condition, taken when true and opcode bit 0 is clear
    typedef enum logic [2:0] {
        CondO,
        CondC,
        CondZ,
        CondBe,
        CondS,
        CondP,
        CondL,
        CondLe
    } condSelT;

    // Same bit layout as the x86 FLAGS low 12 bits
    typedef struct packed {
        logic of;
        logic df;
        logic iF;
        logic tf;
        logic sf;
        logic zf;
        logic pad5;
        logic af;
        logic pad3;
        logic pf;
        logic one;      // Always set
        logic cf;
    } flagsT;

    typedef enum logic [3:0] {
        aluModRm,
        aluAccImm,
        movRegImm,
        incDec,
        jcc,
        jmpRel,
        flagOp,
        inOut,
        nop
    } instrClassT;

    // --------------------
    // Structs between blocks
    typedef struct packed {
        instrClassT cls;
        aluOpT      aluOp;
        logic       wide;        // 16-bit operation
        logic       dirRegRm;    // ModRM reg field is the destination
        regSelT     regIdx;
        condSelT    cond;
        logic       portFromDx;
    } decodedT;

    typedef struct packed {
        logic   en;
        regSelT sel;
        logic   wide;
        wordT   data;
    } regWriteT;

    typedef struct packed {
        wordT addr;
        wordT data;
        logic wide;
        logic write;
        logic read;
    } portReqT;

    // --------------------
    // Constants
    localparam wordT       ResetIp    = 16'hFFF0;
    localparam flagsT      FlagsReset = 12'h002;
    localparam logic [1:0] ModRegReg  = 2'b11;
    localparam int         InReadWait = 2;        // Cycles from portRead to portIn sample
    localparam regSelT     RegAx      = 3'd0;

endpackage
